/* common/apb_fabric_pkg.sv */
`default_nettype none

package apb_fabric_pkg;

    // ~~~~~~~~~~~~~~~~~~~~
    // bus widths
    localparam int addr_width = 32;
    localparam int data_width = 32;
    localparam int strb_width = 4;

    // region map, matched on the top address nibble
    localparam int         num_regions = 4;
    localparam logic [3:0] region_base = 4'ha;

    // delay ratio is counted in sixteenths
    localparam int ratio_frac_bits = 4;

    localparam int slave_words = 16;

    // ~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [1:0] {
        delay_idle,
        delay_request,
        delay_wait
    } delay_state_t;

    typedef enum logic {
        slave_idle,
        slave_access
    } slave_state_t;

endpackage

`default_nettype wire

/* hdl/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_decoder (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic [apb_fabric_pkg::addr_width-1:0]  paddr,
    input  logic                                   psel,
    input  logic                                   penable,
    output logic [apb_fabric_pkg::num_regions-1:0] region_sel,
    output logic                                   miss_sel,
    output logic                                   miss_pready,
    output logic                                   miss_pslverr
);
    import apb_fabric_pkg::*;

    logic [3:0] nibble;
    logic       miss_done;

    assign nibble = paddr[addr_width-1 -: 4];

    // one-hot region select
    always_comb begin
        region_sel = '0;
        for (int i = 0; i < num_regions; i++) begin
            region_sel[i] = psel && (nibble == region_base + 4'(i));
        end
    end

    assign miss_sel = psel && !(|region_sel);

    // ~~~~~~~~~~~~~~~~~~~~
    // unmapped access answered in its first access cycle
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            miss_done <= 1'b0;
        end else if (!psel || !penable) begin
            miss_done <= 1'b0;
        end else if (miss_pready) begin
            miss_done <= 1'b1;
        end
    end

    assign miss_pready  = miss_sel && penable && !miss_done;
    assign miss_pslverr = miss_pready;

    // ~~~~~~~~~~~~~~~~~~~~
    // a held miss must not be answered twice
    miss_single_ready: assert property (
        @(posedge clock) disable iff (reset)
        miss_pready |=> !miss_pready
    );

endmodule

`default_nettype wire

/* apb_delayer/apb_delayer.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_delayer #(
    parameter int ratio_num = 40
) (
    input  logic                                  clock,
    input  logic                                  reset,

    input  logic [apb_fabric_pkg::addr_width-1:0] in_paddr,
    input  logic                                  in_psel,
    input  logic                                  in_penable,
    input  logic [2:0]                            in_pprot,
    input  logic                                  in_pwrite,
    input  logic [apb_fabric_pkg::data_width-1:0] in_pwdata,
    input  logic [apb_fabric_pkg::strb_width-1:0] in_pstrb,
    output logic                                  in_pready,
    output logic [apb_fabric_pkg::data_width-1:0] in_prdata,
    output logic                                  in_pslverr,

    output logic [apb_fabric_pkg::addr_width-1:0] out_paddr,
    output logic                                  out_psel,
    output logic                                  out_penable,
    output logic [2:0]                            out_pprot,
    output logic                                  out_pwrite,
    output logic [apb_fabric_pkg::data_width-1:0] out_pwdata,
    output logic [apb_fabric_pkg::strb_width-1:0] out_pstrb,
    input  logic                                  out_pready,
    input  logic [apb_fabric_pkg::data_width-1:0] out_prdata,
    input  logic                                  out_pslverr
);
    import apb_fabric_pkg::*;

    delay_state_t          state;
    logic [9:0]            count;
    logic [10:0]           sum;
    logic [9:0]            sum_sat;
    logic [data_width-1:0] cap_data;
    logic                  cap_err;
    logic                  release_now;

    // address and data go straight through
    assign out_paddr  = in_paddr;
    assign out_pprot  = in_pprot;
    assign out_pwrite = in_pwrite;
    assign out_pwdata = in_pwdata;
    assign out_pstrb  = in_pstrb;

    // slave must not see a second access while we stretch
    assign out_psel    = in_psel && (state != delay_wait);
    assign out_penable = in_penable && (state != delay_wait);

    // saturating accumulate
    assign sum     = {1'b0, count} + 11'(ratio_num);
    assign sum_sat = sum[10] ? '1 : sum[9:0];

    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= delay_idle;
            count <= '0;
        end else begin
            case (state)
                delay_idle: begin
                    count <= '0;
                    if (in_psel) begin
                        state <= delay_request;
                    end
                end
                delay_request: begin
                    if (out_pready) begin
                        // floor(T * ratio / 16)
                        count <= sum_sat >> ratio_frac_bits;
                        state <= delay_wait;
                    end else begin
                        count <= sum_sat;
                    end
                end
                delay_wait: begin
                    if (count == '0) begin
                        state <= delay_idle;
                    end else begin
                        count <= count - 10'd1;
                    end
                end
                default: state <= delay_idle;
            endcase
        end
    end

    // hold the slave response until release
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cap_data <= '0;
            cap_err  <= 1'b0;
        end else if (state == delay_request && out_pready) begin
            cap_data <= out_prdata;
            cap_err  <= out_pslverr;
        end
    end

    assign release_now = (state == delay_wait) && (count == '0);
    assign in_pready   = release_now;
    assign in_prdata   = release_now ? cap_data : '0;
    assign in_pslverr  = release_now && cap_err;

    // ~~~~~~~~~~~~~~~~~~~~
    // release only to a requester still in its access phase
    release_to_access: assert property (
        @(posedge clock) disable iff (reset)
        in_pready |-> in_psel && in_penable
    );

    // the slave answers only a forwarded request
    slave_ready_in_request: assert property (
        @(posedge clock) disable iff (reset)
        out_pready |-> (state == delay_request)
    );

endmodule

`default_nettype wire

/* hdl/apb_reg_slave.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_reg_slave #(
    parameter int wait_states = 1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [apb_fabric_pkg::addr_width-1:0] paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [apb_fabric_pkg::data_width-1:0] pwdata,
    input  logic [apb_fabric_pkg::strb_width-1:0] pstrb,
    output logic                                  pready,
    output logic [apb_fabric_pkg::data_width-1:0] prdata,
    output logic                                  pslverr
);
    import apb_fabric_pkg::*;

    localparam int index_width = $clog2(slave_words);

    slave_state_t           state;
    logic [7:0]             wait_count;
    logic [data_width-1:0]  bank [slave_words];
    logic [index_width-1:0] index;
    logic                   offset_err;
    logic                   done;

    assign index      = paddr[index_width+1:2];
    assign offset_err = |paddr[27:6];

    // completes once the wait count reaches wait_states
    assign done = (state == slave_access) && (wait_count == 8'(wait_states));

    // ~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= slave_idle;
            wait_count <= '0;
        end else begin
            case (state)
                slave_idle: begin
                    wait_count <= '0;
                    if (psel && penable) begin
                        state <= slave_access;
                    end
                end
                slave_access: begin
                    if (done) begin
                        state <= slave_idle;
                    end else begin
                        wait_count <= wait_count + 8'd1;
                    end
                end
                default: state <= slave_idle;
            endcase
        end
    end

    // strobed bytes only and never on a bad offset
    always_ff @(posedge clock) begin
        if (done && pwrite && !offset_err) begin
            for (int b = 0; b < strb_width; b++) begin
                if (pstrb[b]) begin
                    bank[index][8*b +: 8] <= pwdata[8*b +: 8];
                end
            end
        end
    end

    assign pready  = done;
    assign pslverr = done && offset_err;
    assign prdata  = (done && !pwrite && !offset_err) ? bank[index] : '0;

endmodule

`default_nettype wire

/* hdl/apb_response_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_response_mux (
    input  logic [apb_fabric_pkg::num_regions-1:0] region_sel,
    input  logic                                   miss_sel,
    input  logic                                   miss_pready,
    input  logic                                   miss_pslverr,
    input  logic [apb_fabric_pkg::num_regions-1:0] region_pready,
    input  logic [apb_fabric_pkg::data_width-1:0]  region_prdata
                                                    [apb_fabric_pkg::num_regions],
    input  logic [apb_fabric_pkg::num_regions-1:0] region_pslverr,
    output logic                                   pready,
    output logic [apb_fabric_pkg::data_width-1:0]  prdata,
    output logic                                   pslverr
);
    import apb_fabric_pkg::*;

    // nothing selected returns zeros
    always_comb begin
        pready  = 1'b0;
        prdata  = '0;
        pslverr = 1'b0;
        if (miss_sel) begin
            // miss carries no data
            pready  = miss_pready;
            pslverr = miss_pslverr;
        end else begin
            for (int i = 0; i < num_regions; i++) begin
                if (region_sel[i]) begin
                    pready  = region_pready[i];
                    prdata  = region_prdata[i];
                    pslverr = region_pslverr[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/apb_latency_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_latency_fabric #(
    parameter int ratio_num   = 40,
    parameter int wait_states = 1
) (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [apb_fabric_pkg::addr_width-1:0] paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic [2:0]                            pprot,
    input  logic                                  pwrite,
    input  logic [apb_fabric_pkg::data_width-1:0] pwdata,
    input  logic [apb_fabric_pkg::strb_width-1:0] pstrb,
    output logic                                  pready,
    output logic [apb_fabric_pkg::data_width-1:0] prdata,
    output logic                                  pslverr
);
    import apb_fabric_pkg::*;

    logic [num_regions-1:0] region_sel;
    logic                   miss_sel;
    logic                   miss_pready;
    logic                   miss_pslverr;
    logic [num_regions-1:0] region_pready;
    logic [data_width-1:0]  region_prdata [num_regions];
    logic [num_regions-1:0] region_pslverr;

    apb_decoder i_apb_decoder (
        .clock        (clock),
        .reset        (reset),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .region_sel   (region_sel),
        .miss_sel     (miss_sel),
        .miss_pready  (miss_pready),
        .miss_pslverr (miss_pslverr)
    );

    // ~~~~~~~~~~~~~~~~~~~~
    // one delayer and one register bank per region
    for (genvar i = 0; i < num_regions; i++) begin : g_region
        logic [addr_width-1:0] slv_paddr;
        logic                  slv_psel;
        logic                  slv_penable;
        logic                  slv_pwrite;
        logic [data_width-1:0] slv_pwdata;
        logic [strb_width-1:0] slv_pstrb;
        logic                  slv_pready;
        logic [data_width-1:0] slv_prdata;
        logic                  slv_pslverr;

        apb_delayer #(
            .ratio_num (ratio_num)
        ) i_apb_delayer (
            .clock (clock), .reset (reset),
            .in_paddr (paddr), .in_psel (region_sel[i]), .in_penable (penable),
            .in_pprot (pprot), .in_pwrite (pwrite), .in_pwdata (pwdata),
            .in_pstrb (pstrb), .in_pready (region_pready[i]),
            .in_prdata (region_prdata[i]), .in_pslverr (region_pslverr[i]),
            .out_paddr (slv_paddr), .out_psel (slv_psel), .out_penable (slv_penable),
            .out_pprot (), .out_pwrite (slv_pwrite), .out_pwdata (slv_pwdata),
            .out_pstrb (slv_pstrb), .out_pready (slv_pready),
            .out_prdata (slv_prdata), .out_pslverr (slv_pslverr)
        );

        apb_reg_slave #(
            .wait_states (wait_states)
        ) i_apb_reg_slave (
            .clock (clock), .reset (reset),
            .paddr (slv_paddr), .psel (slv_psel), .penable (slv_penable),
            .pwrite (slv_pwrite), .pwdata (slv_pwdata), .pstrb (slv_pstrb),
            .pready (slv_pready), .prdata (slv_prdata), .pslverr (slv_pslverr)
        );
    end

    apb_response_mux i_apb_response_mux (
        .region_sel     (region_sel),
        .miss_sel       (miss_sel),
        .miss_pready    (miss_pready),
        .miss_pslverr   (miss_pslverr),
        .region_pready  (region_pready),
        .region_prdata  (region_prdata),
        .region_pslverr (region_pslverr),
        .pready         (pready),
        .prdata         (prdata),
        .pslverr        (pslverr)
    );

endmodule

`default_nettype wire

/* tests/tb_apb_latency_fabric.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_apb_latency_fabric;
    import apb_fabric_pkg::*;

    localparam int ratio_num     = 40;
    localparam int wait_states   = 1;
    localparam int ready_timeout = 200;

    logic                  clock = 1'b0;
    logic                  reset;
    logic [addr_width-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic [2:0]            pprot;
    logic                  pwrite;
    logic [data_width-1:0] pwdata;
    logic [strb_width-1:0] pstrb;
    logic                  pready;
    logic [data_width-1:0] prdata;
    logic                  pslverr;

    // byte-wise image of the four banks
    logic [7:0]            model_bytes [num_regions][slave_words][strb_width];
    logic [31:0]           rng_state = 32'd57122;

    string                 name_q [$];
    logic [data_width-1:0] exp_data_q [$];
    logic                  exp_err_q [$];
    int                    exp_lat_q [$];
    logic [data_width-1:0] act_data_q [$];
    logic                  act_err_q [$];
    int                    act_lat_q [$];

    int cycle_count      = 0;
    int setup_cycle      = 0;
    int transfers_issued = 0;
    int compared         = 0;

    apb_latency_fabric #(
        .ratio_num   (ratio_num),
        .wait_states (wait_states)
    ) i_apb_latency_fabric (
        .clock (clock), .reset (reset),
        .paddr (paddr), .psel (psel), .penable (penable), .pprot (pprot),
        .pwrite (pwrite), .pwdata (pwdata), .pstrb (pstrb),
        .pready (pready), .prdata (prdata), .pslverr (pslverr)
    );

    always #20 clock = ~clock;

    // ~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic logic [addr_width-1:0] word_address(int region, int index);
        return {4'(region_base + region), 22'h0, 4'(index), 2'b00};
    endfunction

    // -1 for an unmapped nibble
    function automatic int region_of(logic [addr_width-1:0] addr);
        int region;
        region = int'(addr[31:28]) - int'(region_base);
        return (region >= 0 && region < num_regions) ? region : -1;
    endfunction

    function automatic logic expected_error(logic [addr_width-1:0] addr);
        return (region_of(addr) < 0) || (|addr[27:6]);
    endfunction

    function automatic logic [data_width-1:0] expected_rdata(logic [addr_width-1:0] addr,
                                                             logic write);
        logic [data_width-1:0] word;
        word = '0;
        if (!write && !expected_error(addr)) begin
            for (int b = 0; b < strb_width; b++) begin
                word[8*b +: 8] = model_bytes[region_of(addr)][addr[5:2]][b];
            end
        end
        return word;
    endfunction

    // T counts setup, wait states and completion
    function automatic int expected_latency(logic [addr_width-1:0] addr);
        int t;
        t = wait_states + 2;
        if (region_of(addr) < 0) begin
            return 1;
        end
        return t + ((t * ratio_num) >> ratio_frac_bits) + 1;
    endfunction

    function automatic void model_write(logic [addr_width-1:0] addr,
                                        logic [data_width-1:0] data,
                                        logic [strb_width-1:0] strb);
        for (int b = 0; b < strb_width; b++) begin
            if (strb[b]) begin
                model_bytes[region_of(addr)][addr[5:2]][b] = data[8*b +: 8];
            end
        end
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~
    task automatic stop_on_failure(string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic compare_data(string name, logic [data_width-1:0] exp,
                                logic [data_width-1:0] act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic compare_err(string name, logic exp, logic act);
        if (act !== exp) begin
            stop_on_failure($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic compare_latency(string name, int exp, int act);
        if (act != exp) begin
            stop_on_failure($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic apb_transfer(string name, logic [addr_width-1:0] addr, logic write,
                                logic [data_width-1:0] wdata, logic [strb_width-1:0] strb);
        int   guard;
        logic ready_seen;
        name_q.push_back(name);
        exp_data_q.push_back(expected_rdata(addr, write));
        exp_err_q.push_back(expected_error(addr));
        exp_lat_q.push_back(expected_latency(addr));
        if (write && !expected_error(addr)) begin
            model_write(addr, wdata, strb);
        end
        transfers_issued++;
        @(negedge clock);
        paddr   = addr;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        pwdata  = wdata;
        pstrb   = strb;
        @(negedge clock);
        penable = 1'b1;
        guard = 0;
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(posedge clock);
            ready_seen = pready;
            guard++;
            if (!ready_seen && guard > ready_timeout) begin
                stop_on_failure($sformatf("timeout: no pready for %s at %h", name, addr));
            end
        end
    endtask

    task automatic bus_idle();
        @(negedge clock);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~
    // bus monitor
    always @(posedge clock) begin
        if (!reset) begin
            cycle_count++;
            if (psel && !penable) begin
                setup_cycle = cycle_count;
            end
            if (pready && !(psel && penable)) begin
                stop_on_failure("pready was high outside an access phase");
            end
            if (psel && penable && pready) begin
                act_data_q.push_back(prdata);
                act_err_q.push_back(pslverr);
                act_lat_q.push_back(cycle_count - setup_cycle);
            end
        end
    end

    initial begin
        string test_name;
        forever begin
            @(negedge clock);
            while (act_lat_q.size() > 0) begin
                if (exp_lat_q.size() == 0) begin
                    stop_on_failure("a transfer completed that was never issued");
                end
                test_name = name_q.pop_front();
                compare_data(test_name, exp_data_q.pop_front(), act_data_q.pop_front());
                compare_err(test_name, exp_err_q.pop_front(), act_err_q.pop_front());
                compare_latency(test_name, exp_lat_q.pop_front(), act_lat_q.pop_front());
                compared++;
            end
        end
    end

    initial begin
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] data;
        logic [31:0]           rnd;
        int                    guard;
        reset   = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pprot   = 3'b000;
        pwrite  = 1'b0;
        pwdata  = '0;
        pstrb   = '0;
        repeat (16) @(negedge clock);
        reset = 1'b0;

        repeat (8) begin
            @(posedge clock);
            compare_err("idle_pready", 1'b0, pready);
            compare_err("idle_pslverr", 1'b0, pslverr);
        end

        // every word gets a known value first
        for (int r = 0; r < num_regions; r++) begin
            for (int w = 0; w < slave_words; w++) begin
                apb_transfer("fill", word_address(r, w), 1'b1, next_random(), 4'hf);
            end
        end
        bus_idle();

        repeat (40) begin
            addr = word_address(next_random() % num_regions, next_random() % slave_words);
            data = next_random();
            rnd  = next_random();
            apb_transfer("rand_write", addr, 1'b1, data, rnd[3:0]);
            apb_transfer("rand_read", addr, 1'b0, '0, '0);
        end
        bus_idle();

        // bad offset must leave the bank alone
        addr = word_address(1, 5);
        apb_transfer("offset_write", addr | (32'h1 << (6 + next_random() % 22)), 1'b1,
                     next_random(), 4'hf);
        apb_transfer("offset_read", addr | 32'h0800_0000, 1'b0, '0, '0);
        apb_transfer("offset_check", addr, 1'b0, '0, '0);
        bus_idle();

        apb_transfer("unmapped_write", 32'h3000_0010, 1'b1, next_random(), 4'hf);
        apb_transfer("unmapped_read", 32'he000_0004, 1'b0, '0, '0);
        apb_transfer("unmapped_zero", 32'h0000_0000, 1'b0, '0, '0);

        // back to back across regions with a miss between
        for (int r = 0; r < num_regions; r++) begin
            apb_transfer("b2b_read", word_address(r, r + 3), 1'b0, '0, '0);
            if (r == 1) begin
                apb_transfer("b2b_miss", 32'hf000_0008, 1'b0, '0, '0);
            end
        end
        bus_idle();

        guard = 0;
        while (compared < transfers_issued) begin
            @(posedge clock);
            guard++;
            if (guard > ready_timeout) begin
                stop_on_failure("timeout: results of issued transfers never checked");
            end
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
common/apb_fabric_pkg.sv
hdl/apb_decoder.sv
apb_delayer/apb_delayer.sv
hdl/apb_reg_slave.sv
hdl/apb_response_mux.sv
hdl/apb_latency_fabric.sv
tests/tb_apb_latency_fabric.sv
